/* mixer_cfg_pkg.sv */
//////////////////////////////
// mixer configuration
// audio and gain formats, channel count, clip hold time
// and the shared Q-format multiply and saturate helpers
//////////////////////////////

`default_nettype none

package mixer_cfg_pkg;

  localparam int AUDIO_WIDTH      = 24;
  localparam int GAIN_WIDTH       = 16;
  localparam int Q_BITS           = 12;  // gain and pan fraction bits
  localparam int NR_CHANNELS      = 4;
  localparam int CLIP_HOLD_CYCLES = 200;

  localparam int SUM_WIDTH      = AUDIO_WIDTH + $clog2(NR_CHANNELS);  // channel adder tree
  localparam int WIDE_WIDTH     = AUDIO_WIDTH + GAIN_WIDTH + 8;        // product headroom
  localparam int CLIP_CNT_WIDTH = $clog2(CLIP_HOLD_CYCLES + 1);

  typedef logic signed [AUDIO_WIDTH-1:0] audio_t;
  typedef logic        [GAIN_WIDTH-1:0]  gain_t;
  typedef logic        [NR_CHANNELS-1:0] chan_mask_t;
  typedef logic signed [SUM_WIDTH-1:0]   sum_t;
  typedef logic signed [WIDE_WIDTH-1:0]  wide_t;
  typedef logic [CLIP_CNT_WIDTH-1:0]     clip_cnt_t;

  localparam gain_t  GAIN_ONE  = gain_t'(1 << Q_BITS);  // unity, 4096
  localparam audio_t AUDIO_MAX = {1'b0, {(AUDIO_WIDTH-1){1'b1}}};
  localparam audio_t AUDIO_MIN = {1'b1, {(AUDIO_WIDTH-1){1'b0}}};

  // signed value times unsigned Q gain, back to integer scale
  function automatic wide_t q_mul(input wide_t a, input gain_t g);
    return (a * wide_t'(g)) >>> Q_BITS;
  endfunction

  // clamp a wide result into the audio range
  function automatic audio_t sat_audio(input wide_t v);
    if (v > wide_t'(AUDIO_MAX)) begin
      return AUDIO_MAX;
    end else if (v < wide_t'(AUDIO_MIN)) begin
      return AUDIO_MIN;
    end
    return audio_t'(v);
  endfunction

endpackage

`default_nettype wire

/* mixer_dac_pkg.sv */
//////////////////////////////
// DAC stream definitions
// word format and the left/right sequencer states
//////////////////////////////

`default_nettype none

package mixer_dac_pkg;

  localparam int DAC_WIDTH = 24;

  // one word on the DAC stream, left or right sample
  typedef logic [DAC_WIDTH-1:0] dac_word_t;

  //////////////////////////////
  // sequencer states
  //////////////////////////////

  // idle waits for a mixed pair, then the two words go out in order
  typedef enum logic [1:0] {
    DAC_IDLE       = 2'd0,
    DAC_SEND_LEFT  = 2'd1,  // left word on the bus
    DAC_SEND_RIGHT = 2'd2   // right word, dac_last high
  } dac_state_t;

endpackage

`default_nettype wire

/* mixer_channel_stage.sv */
//////////////////////////////
// mixer channel stage
// per-channel gain and pan, saturation and clip flags
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mixer_channel_stage (
  input  wire                                                    clk,
  input  wire                                                    rst_n,

  input  wire                                                    x_valid,
  input  wire mixer_cfg_pkg::audio_t [mixer_cfg_pkg::NR_CHANNELS-1:0] x_data,
  input  wire mixer_cfg_pkg::gain_t  [mixer_cfg_pkg::NR_CHANNELS-1:0] cr_mix_channel_gain,
  input  wire mixer_cfg_pkg::gain_t  [mixer_cfg_pkg::NR_CHANNELS-1:0] cr_mix_channel_pan,

  output logic                                                   ch_valid,
  output mixer_cfg_pkg::audio_t [mixer_cfg_pkg::NR_CHANNELS-1:0] ch_left,
  output mixer_cfg_pkg::audio_t [mixer_cfg_pkg::NR_CHANNELS-1:0] ch_right,
  output mixer_cfg_pkg::chan_mask_t                              chan_clip
);

  import mixer_cfg_pkg::*;

  wide_t      scaled_w [NR_CHANNELS];  // gain applied, before saturation
  audio_t     scaled   [NR_CHANNELS];
  gain_t      pan_c    [NR_CHANNELS];
  audio_t     left_c   [NR_CHANNELS];
  audio_t     right_c  [NR_CHANNELS];
  chan_mask_t clip_c;

  //////////////////////////////
  // gain and pan
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NR_CHANNELS; i++) begin
      scaled_w[i] = q_mul(wide_t'(x_data[i]), cr_mix_channel_gain[i]);
      scaled[i]   = sat_audio(scaled_w[i]);
      clip_c[i]   = (scaled_w[i] != wide_t'(scaled[i]));  // value changed by clamp

      // pan past unity is held at unity
      if (cr_mix_channel_pan[i] > GAIN_ONE) begin
        pan_c[i] = GAIN_ONE;
      end else begin
        pan_c[i] = cr_mix_channel_pan[i];
      end

      // pan <= 1, so magnitude never grows and truncation is safe
      right_c[i] = audio_t'(q_mul(wide_t'(scaled[i]), pan_c[i]));
      left_c[i]  = audio_t'(q_mul(wide_t'(scaled[i]), GAIN_ONE - pan_c[i]));
    end
  end

  //////////////////////////////
  // output registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ch_valid  <= 1'b0;
      chan_clip <= '0;
    end else begin
      ch_valid <= x_valid;
      if (x_valid) begin
        chan_clip <= clip_c;  // held until next sample
      end
    end
  end

  always_ff @(posedge clk) begin
    if (x_valid) begin
      for (int i = 0; i < NR_CHANNELS; i++) begin
        ch_left[i]  <= left_c[i];
        ch_right[i] <= right_c[i];
      end
    end
  end

endmodule

`default_nettype wire

/* mixer_sum.sv */
//////////////////////////////
// mixer sum stage
// adds channels per side, applies output gain, saturates
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mixer_sum (
  input  wire                                                    clk,
  input  wire                                                    rst_n,

  input  wire                                                    ch_valid,
  input  wire mixer_cfg_pkg::audio_t [mixer_cfg_pkg::NR_CHANNELS-1:0] ch_left,
  input  wire mixer_cfg_pkg::audio_t [mixer_cfg_pkg::NR_CHANNELS-1:0] ch_right,
  input  wire mixer_cfg_pkg::gain_t                              cr_mix_output_gain,

  output logic                                                   mix_valid,
  output mixer_cfg_pkg::audio_t                                  mix_left,
  output mixer_cfg_pkg::audio_t                                  mix_right,
  output logic                                                   out_clip
);

  import mixer_cfg_pkg::*;

  sum_t   sum_left_c;
  sum_t   sum_right_c;
  sum_t   sum_left_q;   // first register, raw channel sums
  sum_t   sum_right_q;
  logic   sum_valid;

  wide_t  gained_left;
  wide_t  gained_right;
  audio_t sat_left;
  audio_t sat_right;
  logic   clip_c;

  //////////////////////////////
  // adder tree
  //////////////////////////////

  always_comb begin
    sum_left_c  = '0;
    sum_right_c = '0;
    for (int i = 0; i < NR_CHANNELS; i++) begin
      sum_left_c  += sum_t'(ch_left[i]);
      sum_right_c += sum_t'(ch_right[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= ch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ch_valid) begin
      sum_left_q  <= sum_left_c;
      sum_right_q <= sum_right_c;
    end
  end

  //////////////////////////////
  // output gain and clamp
  //////////////////////////////

  assign gained_left  = q_mul(wide_t'(sum_left_q), cr_mix_output_gain);
  assign gained_right = q_mul(wide_t'(sum_right_q), cr_mix_output_gain);
  assign sat_left     = sat_audio(gained_left);
  assign sat_right    = sat_audio(gained_right);
  assign clip_c       = (gained_left  != wide_t'(sat_left)) ||
                        (gained_right != wide_t'(sat_right));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mix_valid <= 1'b0;
      out_clip  <= 1'b0;
    end else begin
      mix_valid <= sum_valid;
      if (sum_valid) begin
        out_clip <= clip_c;  // either side clamped
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      mix_left  <= sat_left;
      mix_right <= sat_right;
    end
  end

endmodule

`default_nettype wire

/* mixer_egress.sv */
//////////////////////////////
// mixer egress
// sends left then right word to the DAC, tracks min/max
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mixer_egress (
  input  wire                       clk,
  input  wire                       rst_n,

  input  wire                       mix_valid,
  input  wire mixer_cfg_pkg::audio_t mix_left,
  input  wire mixer_cfg_pkg::audio_t mix_right,
  input  wire                       dac_ready,
  input  wire                       cmd_mix_clear_dac_min_max,

  output mixer_dac_pkg::dac_word_t  dac_data,
  output logic                      dac_valid,
  output logic                      dac_last,
  output mixer_cfg_pkg::audio_t     sr_mix_max_dac_amplitude,
  output mixer_cfg_pkg::audio_t     sr_mix_min_dac_amplitude
);

  import mixer_cfg_pkg::*;
  import mixer_dac_pkg::*;

  dac_state_t dac_state;
  dac_word_t  right_hold;  // right word waits here while left is out
  logic       dac_accept;
  audio_t     acc_word;

  assign dac_accept = dac_valid && dac_ready;
  assign acc_word   = audio_t'(dac_data);

  //////////////////////////////
  // word sequencer
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dac_state <= DAC_IDLE;
      dac_valid <= 1'b0;
      dac_last  <= 1'b0;
    end else begin
      case (dac_state)
        DAC_IDLE: begin
          if (mix_valid) begin  // pairs arriving while busy are dropped
            dac_state <= DAC_SEND_LEFT;
            dac_valid <= 1'b1;
            dac_last  <= 1'b0;
          end
        end
        DAC_SEND_LEFT: begin
          if (dac_ready) begin
            dac_state <= DAC_SEND_RIGHT;
            dac_last  <= 1'b1;
          end
        end
        DAC_SEND_RIGHT: begin
          if (dac_ready) begin
            dac_state <= DAC_IDLE;
            dac_valid <= 1'b0;
            dac_last  <= 1'b0;
          end
        end
        default: dac_state <= DAC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (dac_state == DAC_IDLE && mix_valid) begin
      dac_data   <= dac_word_t'(mix_left);
      right_hold <= dac_word_t'(mix_right);
    end else if (dac_state == DAC_SEND_LEFT && dac_ready) begin
      dac_data <= right_hold;
    end
  end

  //////////////////////////////
  // amplitude tracking
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sr_mix_min_dac_amplitude <= AUDIO_MAX;
      sr_mix_max_dac_amplitude <= AUDIO_MIN;
    end else if (cmd_mix_clear_dac_min_max) begin
      sr_mix_min_dac_amplitude <= AUDIO_MAX;
      sr_mix_max_dac_amplitude <= AUDIO_MIN;
    end else if (dac_accept) begin
      if (acc_word < sr_mix_min_dac_amplitude) begin
        sr_mix_min_dac_amplitude <= acc_word;
      end
      if (acc_word > sr_mix_max_dac_amplitude) begin
        sr_mix_max_dac_amplitude <= acc_word;
      end
    end
  end

endmodule

`default_nettype wire

/* mixer_clip_led.sv */
//////////////////////////////
// clip LED
// lit for a fixed hold time after any clip
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mixer_clip_led (
  input  wire                            clk,
  input  wire                            rst_n,

  input  wire mixer_cfg_pkg::chan_mask_t chan_clip,
  input  wire                            out_clip,

  output logic                           clip_led
);

  import mixer_cfg_pkg::*;

  clip_cnt_t hold_cnt;
  logic      any_clip;

  assign any_clip = (|chan_clip) || out_clip;

  // reload on every clip, count down to zero otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt <= '0;
    end else if (any_clip) begin
      hold_cnt <= clip_cnt_t'(CLIP_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign clip_led = (hold_cnt != '0);

endmodule

`default_nettype wire

/* mixer_top.sv */
//////////////////////////////
// mixer top
// channel stage, sum stage, DAC egress and clip LED
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mixer_top (
  input  wire                                                    clk,
  input  wire                                                    rst_n,

  // samples and strobe
  input  wire                                                    x_valid,
  input  wire mixer_cfg_pkg::audio_t [mixer_cfg_pkg::NR_CHANNELS-1:0] x_data,

  // DAC stream
  output mixer_dac_pkg::dac_word_t                               dac_data,
  output logic                                                   dac_valid,
  input  wire                                                    dac_ready,
  output logic                                                   dac_last,

  output logic                                                   clip_led,

  // control and status
  input  wire                                                    cmd_mix_clear_dac_min_max,
  input  wire mixer_cfg_pkg::gain_t  [mixer_cfg_pkg::NR_CHANNELS-1:0] cr_mix_channel_gain,
  input  wire mixer_cfg_pkg::gain_t  [mixer_cfg_pkg::NR_CHANNELS-1:0] cr_mix_channel_pan,
  input  wire mixer_cfg_pkg::gain_t                              cr_mix_output_gain,
  output logic                                                   sr_mix_out_clip,
  output mixer_cfg_pkg::chan_mask_t                              sr_mix_channel_clip,
  output mixer_cfg_pkg::audio_t                                  sr_mix_max_dac_amplitude,
  output mixer_cfg_pkg::audio_t                                  sr_mix_min_dac_amplitude
);

  import mixer_cfg_pkg::*;

  logic                      ch_valid;
  audio_t [NR_CHANNELS-1:0]  ch_left;
  audio_t [NR_CHANNELS-1:0]  ch_right;
  logic                      mix_valid;
  audio_t                    mix_left;
  audio_t                    mix_right;

  mixer_channel_stage u_channel_stage (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .x_valid             ( x_valid             ),
    .x_data              ( x_data              ),
    .cr_mix_channel_gain ( cr_mix_channel_gain ),
    .cr_mix_channel_pan  ( cr_mix_channel_pan  ),
    .ch_valid            ( ch_valid            ),
    .ch_left             ( ch_left             ),
    .ch_right            ( ch_right            ),
    .chan_clip           ( sr_mix_channel_clip )
  );

  mixer_sum u_sum (
    .clk                ( clk                ),
    .rst_n              ( rst_n              ),
    .ch_valid           ( ch_valid           ),
    .ch_left            ( ch_left            ),
    .ch_right           ( ch_right           ),
    .cr_mix_output_gain ( cr_mix_output_gain ),
    .mix_valid          ( mix_valid          ),
    .mix_left           ( mix_left           ),
    .mix_right          ( mix_right          ),
    .out_clip           ( sr_mix_out_clip    )
  );

  mixer_egress u_egress (
    .clk                       ( clk                       ),
    .rst_n                     ( rst_n                     ),
    .mix_valid                 ( mix_valid                 ),
    .mix_left                  ( mix_left                  ),
    .mix_right                 ( mix_right                 ),
    .dac_ready                 ( dac_ready                 ),
    .cmd_mix_clear_dac_min_max ( cmd_mix_clear_dac_min_max ),
    .dac_data                  ( dac_data                  ),
    .dac_valid                 ( dac_valid                 ),
    .dac_last                  ( dac_last                  ),
    .sr_mix_max_dac_amplitude  ( sr_mix_max_dac_amplitude  ),
    .sr_mix_min_dac_amplitude  ( sr_mix_min_dac_amplitude  )
  );

  mixer_clip_led u_clip_led (
    .clk       ( clk                 ),
    .rst_n     ( rst_n               ),
    .chan_clip ( sr_mix_channel_clip ),
    .out_clip  ( sr_mix_out_clip     ),
    .clip_led  ( clip_led            )
  );

endmodule

`default_nettype wire

/* mixer_sva.sv */
//////////////////////////////
// DAC stream assertions
// last flag, stall hold and reset state, bound to mixer_top
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mixer_sva (
  input wire                           clk,
  input wire                           rst_n,
  input wire                           dac_valid,
  input wire                           dac_ready,
  input wire                           dac_last,
  input wire mixer_dac_pkg::dac_word_t dac_data
);

  int unsigned last_errors   = 0;  // failure counts per property
  int unsigned stable_errors = 0;
  int unsigned reset_errors  = 0;

  // last flag only rides on a valid word
  a_last_with_valid: assert property (
    @(posedge clk) disable iff (!rst_n) dac_last |-> dac_valid)
    else begin
      last_errors++;
      $error("dac_last high without dac_valid");
    end

  a_hold_while_stalled: assert property (
    @(posedge clk) disable iff (!rst_n)
    (dac_valid && !dac_ready) |=> (dac_valid && $stable(dac_data) && $stable(dac_last)))
    else begin
      stable_errors++;
      $error("DAC word changed while waiting for dac_ready");
    end

  a_idle_from_reset: assert property (
    @(posedge clk) (!rst_n || $rose(rst_n)) |-> (!dac_valid && !dac_last))
    else begin
      reset_errors++;
      $error("DAC stream active during or right after reset");
    end

endmodule

bind mixer_top mixer_sva u_sva (
  .clk       ( clk       ),
  .rst_n     ( rst_n     ),
  .dac_valid ( dac_valid ),
  .dac_ready ( dac_ready ),
  .dac_last  ( dac_last  ),
  .dac_data  ( dac_data  )
);

`default_nettype wire

/* tb_mixer_top.sv */
//////////////////////////////
// mixer testbench
// directed and random rows through mixer_top, DAC sink
// with stalls, clip flags, clip LED and min/max checks
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_mixer_top;

  import mixer_cfg_pkg::*;
  import mixer_dac_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int NR_ROWS      = 6;
  localparam int NR_RANDOM    = 24;
  localparam int PIPE_LATENCY = 4;   // x_valid to dac_valid
  localparam int WAIT_LIMIT   = 32;
  localparam int LED_MARGIN   = 16;

  logic                     clk;
  logic                     rst_n;
  logic                     x_valid;
  audio_t [NR_CHANNELS-1:0] x_data;
  gain_t  [NR_CHANNELS-1:0] cr_mix_channel_gain;
  gain_t  [NR_CHANNELS-1:0] cr_mix_channel_pan;
  gain_t                    cr_mix_output_gain;
  logic                     cmd_mix_clear_dac_min_max;
  dac_word_t                dac_data;
  logic                     dac_valid;
  logic                     dac_ready;
  logic                     dac_last;
  logic                     clip_led;
  logic                     sr_mix_out_clip;
  chan_mask_t               sr_mix_channel_clip;
  audio_t                   sr_mix_max_dac_amplitude;
  audio_t                   sr_mix_min_dac_amplitude;

  audio_t exp_min;  // running extremes of accepted words
  audio_t exp_max;
  integer seed = 26;

  //////////////////////////////
  // directed rows
  //////////////////////////////

  int t_x [NR_ROWS][NR_CHANNELS] = '{
    '{    1000,     2000, -3000, 400},  // pan spread
    '{  100000,   -50000,     0,   7},  // gains 2.0 and 0.5, all right
    '{ 3000000, -3000000,    10,   0},  // channel clips, all left
    '{ 8000000,  8000000,  -100,   0},  // output clip on right
    '{ -123456,     5000,     0,   0},  // pan above unity
    '{      -5,        0,     0,   0}   // floor rounding
  };
  int t_gain [NR_ROWS][NR_CHANNELS] = '{
    '{ 4096,  4096, 4096, 4096},
    '{ 8192,  2048, 4096, 4096},
    '{16384, 16384, 4096, 4096},
    '{ 4096,  4096, 4096, 4096},
    '{ 4096,  4096, 4096, 4096},
    '{ 2048,  4096, 4096, 4096}
  };
  int t_pan [NR_ROWS][NR_CHANNELS] = '{
    '{    0, 4096, 2048, 1024},
    '{ 4096, 4096, 4096, 4096},
    '{    0,    0,    0,    0},
    '{ 4096, 4096,    0,    0},
    '{65535, 8192, 4096, 4096},
    '{ 1024, 2048, 2048, 2048}
  };
  int t_out_gain [NR_ROWS] = '{4096, 2048, 4096, 4096, 4096, 12288};
  int t_stall    [NR_ROWS] = '{0, 3, 1, 2, 0, 1};
  int t_left     [NR_ROWS] = '{-200, 0, 9, -100, 0, -9};
  int t_right    [NR_ROWS] = '{600, 87503, 0, 8388607, -118456, -3};
  int t_mask     [NR_ROWS] = '{0, 0, 3, 0, 0, 0};
  int t_clip     [NR_ROWS] = '{0, 0, 0, 1, 0, 0};

  mixer_top u_dut (
    .clk                       ( clk                       ),
    .rst_n                     ( rst_n                     ),
    .x_valid                   ( x_valid                   ),
    .x_data                    ( x_data                    ),
    .dac_data                  ( dac_data                  ),
    .dac_valid                 ( dac_valid                 ),
    .dac_ready                 ( dac_ready                 ),
    .dac_last                  ( dac_last                  ),
    .clip_led                  ( clip_led                  ),
    .cmd_mix_clear_dac_min_max ( cmd_mix_clear_dac_min_max ),
    .cr_mix_channel_gain       ( cr_mix_channel_gain       ),
    .cr_mix_channel_pan        ( cr_mix_channel_pan        ),
    .cr_mix_output_gain        ( cr_mix_output_gain        ),
    .sr_mix_out_clip           ( sr_mix_out_clip           ),
    .sr_mix_channel_clip       ( sr_mix_channel_clip       ),
    .sr_mix_max_dac_amplitude  ( sr_mix_max_dac_amplitude  ),
    .sr_mix_min_dac_amplitude  ( sr_mix_min_dac_amplitude  )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_audio(input string name, input audio_t exp, input audio_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "audio value mismatch");
    end
  endtask

  task automatic check_mask(input string name, input chan_mask_t exp, input chan_mask_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "clip mask mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  // gain, pan clamp, per-side sum, output gain and saturation
  task automatic model_mix(input audio_t [NR_CHANNELS-1:0] x, input gain_t [NR_CHANNELS-1:0] g,
                           input gain_t [NR_CHANNELS-1:0] p, input gain_t og,
                           output audio_t l, output audio_t r,
                           output chan_mask_t m, output logic clip);
    longint hi;
    longint lo;
    longint unity;
    longint s;
    longint pan;
    longint sum_l;
    longint sum_r;
    longint out_l;
    longint out_r;
    hi    = longint'(AUDIO_MAX);
    lo    = longint'(AUDIO_MIN);
    unity = longint'(GAIN_ONE);
    sum_l = 0;
    sum_r = 0;
    m     = '0;
    clip  = 1'b0;
    for (int ch = 0; ch < NR_CHANNELS; ch++) begin
      s = (longint'(x[ch]) * longint'(g[ch])) >>> Q_BITS;
      if (s > hi) begin
        s     = hi;
        m[ch] = 1'b1;
      end else if (s < lo) begin
        s     = lo;
        m[ch] = 1'b1;
      end
      pan   = (longint'(p[ch]) > unity) ? unity : longint'(p[ch]);
      sum_r = sum_r + ((s * pan) >>> Q_BITS);
      sum_l = sum_l + ((s * (unity - pan)) >>> Q_BITS);
    end
    out_l = (sum_l * longint'(og)) >>> Q_BITS;
    out_r = (sum_r * longint'(og)) >>> Q_BITS;
    if (out_l > hi || out_l < lo || out_r > hi || out_r < lo) clip = 1'b1;
    out_l = (out_l > hi) ? hi : ((out_l < lo) ? lo : out_l);
    out_r = (out_r > hi) ? hi : ((out_r < lo) ? lo : out_r);
    l = audio_t'(out_l);
    r = audio_t'(out_r);
  endtask

  task automatic check_word(input string name, input audio_t exp, input logic last);
    check_bit("dac_valid", 1'b1, dac_valid);
    check_audio(name, exp, audio_t'(dac_data));
    check_bit("dac_last", last, dac_last);
  endtask

  // DAC sink, ready held low for the stall count
  task automatic send_word(input string name, input audio_t exp, input logic last,
                           input int stall);
    check_word(name, exp, last);
    for (int i = 0; i < stall; i++) begin
      dac_ready = 1'b0;
      @(negedge clk);
      check_word(name, exp, last);  // held while stalled
    end
    dac_ready = 1'b1;
    @(negedge clk);
    dac_ready = 1'b0;
  endtask

  task automatic track_word(input audio_t w);
    if (w < exp_min) exp_min = w;
    if (w > exp_max) exp_max = w;
  endtask

  // inputs already set, strobe one sample and drain both words
  task automatic run_sample(input int stall, input audio_t exp_l, input audio_t exp_r,
                            input chan_mask_t exp_m, input logic exp_c);
    int lat;
    lat     = 0;
    x_valid = 1'b1;
    do begin
      @(negedge clk);
      x_valid = 1'b0;
      lat++;
    end while (!dac_valid && lat < WAIT_LIMIT);
    if (!dac_valid) abort_run("timeout waiting for dac_valid");
    if (lat != PIPE_LATENCY) abort_run($sformatf("dac_valid rose %0d cycles after x_valid", lat));
    check_mask("sr_mix_channel_clip", exp_m, sr_mix_channel_clip);
    check_bit("sr_mix_out_clip", exp_c, sr_mix_out_clip);
    send_word("dac_data left", exp_l, 1'b0, stall);
    send_word("dac_data right", exp_r, 1'b1, stall);
    check_bit("dac_valid", 1'b0, dac_valid);
    if (exp_m != '0 || exp_c) check_bit("clip_led", 1'b1, clip_led);
    track_word(exp_l);
    track_word(exp_r);
  endtask

  task automatic apply_table_row(input int r);
    for (int ch = 0; ch < NR_CHANNELS; ch++) begin
      x_data[ch]              = audio_t'(t_x[r][ch]);
      cr_mix_channel_gain[ch] = gain_t'(t_gain[r][ch]);
      cr_mix_channel_pan[ch]  = gain_t'(t_pan[r][ch]);
    end
    cr_mix_output_gain = gain_t'(t_out_gain[r]);
    run_sample(t_stall[r], audio_t'(t_left[r]), audio_t'(t_right[r]),
               chan_mask_t'(t_mask[r]), t_clip[r] != 0);
  endtask

  task automatic apply_random_row();
    audio_t     exp_l;
    audio_t     exp_r;
    chan_mask_t exp_m;
    logic       exp_c;
    int         stall;
    for (int ch = 0; ch < NR_CHANNELS; ch++) begin
      x_data[ch]              = audio_t'($random(seed));
      cr_mix_channel_gain[ch] = gain_t'($random(seed) & 32'h1fff);  // up to 2x
      cr_mix_channel_pan[ch]  = gain_t'($random(seed) & 32'h1fff);  // half clamp
    end
    cr_mix_output_gain = gain_t'($random(seed) & 32'h1fff);
    stall              = int'($random(seed) & 32'h3);
    model_mix(x_data, cr_mix_channel_gain, cr_mix_channel_pan, cr_mix_output_gain,
              exp_l, exp_r, exp_m, exp_c);
    run_sample(stall, exp_l, exp_r, exp_m, exp_c);
  endtask

  task automatic check_min_max();
    check_audio("sr_mix_min_dac_amplitude", exp_min, sr_mix_min_dac_amplitude);
    check_audio("sr_mix_max_dac_amplitude", exp_max, sr_mix_max_dac_amplitude);
  endtask

  task automatic clear_min_max();
    cmd_mix_clear_dac_min_max = 1'b1;
    @(negedge clk);
    cmd_mix_clear_dac_min_max = 1'b0;
    exp_min = AUDIO_MAX;
    exp_max = AUDIO_MIN;
    check_min_max();
  endtask

  task automatic wait_led_off();
    int cnt;
    cnt = 0;
    while (clip_led && cnt < CLIP_HOLD_CYCLES + LED_MARGIN) begin
      @(negedge clk);
      cnt++;
    end
    if (clip_led) abort_run("clip_led still lit after the hold time");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    $timeformat(-9, 2, " ns", 10);
    clk                       = 1'b0;
    rst_n                     = 1'b0;
    x_valid                   = 1'b0;
    x_data                    = '0;
    cr_mix_channel_gain       = '0;
    cr_mix_channel_pan        = '0;
    cr_mix_output_gain        = '0;
    cmd_mix_clear_dac_min_max = 1'b0;
    dac_ready                 = 1'b0;
    exp_min                   = AUDIO_MAX;
    exp_max                   = AUDIO_MIN;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_bit("dac_valid", 1'b0, dac_valid);
    check_bit("clip_led", 1'b0, clip_led);
    check_min_max();

    for (int r = 0; r < NR_ROWS; r++) begin
      apply_table_row(r);
    end
    check_min_max();
    clear_min_max();

    repeat (NR_RANDOM) apply_random_row();
    check_min_max();

    // one clipping row, then a clean one lets the LED time out
    apply_table_row(3);
    apply_table_row(0);
    wait_led_off();

    if ((u_dut.u_sva.last_errors + u_dut.u_sva.stable_errors +
         u_dut.u_sva.reset_errors) != 0) begin
      $display("Simulation failed");
      $fatal(1, "stream assertions fired");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* mixer.f */
mixer_cfg_pkg.sv
mixer_dac_pkg.sv
mixer_channel_stage.sv
mixer_sum.sv
mixer_egress.sv
mixer_clip_led.sv
mixer_top.sv
mixer_sva.sv
tb_mixer_top.sv

/* Makefile */
# Verilator build and run for the mixer testbench

VERILATOR ?= verilator
TOP       ?= tb_mixer_top
FILELIST  ?= mixer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || \
		(echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
